// File: Makefile
TOP       ?= tb_comp_unit
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the simulation"
	@echo "make clean  remove $(BUILD_DIR)"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f src.f
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '** PASS **'

clean:
	rm -rf $(BUILD_DIR)

// File: rtl/comp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module comp_unit (
   input  logic             clk,
   input  logic             rst_n,
   input  cu_pkg::ll_beat_t tx_beat_i,
   input  logic             tx_src_rdy_n_i,
   output logic             tx_dst_rdy_n_o,
   output cu_pkg::ll_beat_t rx_beat_o,
   output logic             rx_src_rdy_n_o,
   input  logic             rx_dst_rdy_n_i
);
   import cu_pkg::*;

   logic       pay_take;
   logic       pay_end;
   logic       pay_done;
   logic       trl_done;
   logic       push;
   logic       pop;
   logic       full;
   logic       empty;
   hdr_t       hdr;
   egr_state_e egr_state;
   entry_t     push_entry;
   entry_t     head_entry;

   cu_ctrl u_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_beat_i      (tx_beat_i),
      .tx_src_rdy_n_i (tx_src_rdy_n_i),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .fifo_full_i    (full),
      .pay_take_o     (pay_take),
      .pay_end_o      (pay_end),
      .hdr_o          (hdr),
      .egr_state_o    (egr_state),
      .pay_done_i     (pay_done),
      .trl_done_i     (trl_done)
   );

   cu_pack u_pack (
      .clk     (clk),
      .rst_n   (rst_n),
      .beat_i  (tx_beat_i),
      .take_i  (pay_take),
      .push_o  (push),
      .entry_o (push_entry)
   );

   cu_fifo u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .push_i  (push),
      .entry_i (push_entry),
      .pop_i   (pop),
      .entry_o (head_entry),
      .full_o  (full),
      .empty_o (empty)
   );

   cu_egress u_egress (
      .clk            (clk),
      .rst_n          (rst_n),
      .egr_state_i    (egr_state),
      .hdr_i          (hdr),
      .pay_end_i      (pay_end),
      .entry_i        (head_entry),
      .empty_i        (empty),
      .pop_o          (pop),
      .pay_done_o     (pay_done),
      .trl_done_o     (trl_done),
      .rx_beat_o      (rx_beat_o),
      .rx_src_rdy_n_o (rx_src_rdy_n_o),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i)
   );

endmodule

`default_nettype wire

// File: rtl/cu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cu_ctrl (
   input  logic               clk,
   input  logic               rst_n,
   input  cu_pkg::ll_beat_t   tx_beat_i,
   input  logic               tx_src_rdy_n_i,
   output logic               tx_dst_rdy_n_o,
   input  logic               fifo_full_i,
   output logic               pay_take_o,
   output logic               pay_end_o,
   output cu_pkg::hdr_t       hdr_o,
   output cu_pkg::egr_state_e egr_state_o,
   input  logic               pay_done_i,
   input  logic               trl_done_i
);
   import cu_pkg::*;

   ing_state_e           ing_q;
   ing_state_e           ing_d;
   egr_state_e           egr_q;
   egr_state_e           egr_d;
   logic [HDR_CNT_W-1:0] hdr_cnt_q;
   hdr_t                 hdr_q;
   logic                 tx_xfer;
   logic                 hdr_last;
   logic                 frame_eof;
   logic                 is_copy;
   logic                 eop_take_q;
   logic                 pay_end_q;

   // stall on a full FIFO and while the trailer is still going out
   assign tx_dst_rdy_n_o = fifo_full_i || (ing_q == ING_WAIT);
   assign tx_xfer        = !tx_src_rdy_n_i && !tx_dst_rdy_n_o;
   assign is_copy        = hdr_q.op == OP_COPY;
   assign hdr_last       = (ing_q == ING_HEAD) && tx_xfer &&
                           (hdr_cnt_q == HDR_CNT_W'(HDR_WORDS - 1));
   assign frame_eof      = !tx_beat_i.eof_n &&
                           (hdr_last || ((ing_q == ING_PAYLOAD) && tx_xfer));
   assign pay_take_o     = (ing_q == ING_PAYLOAD) && tx_xfer && is_copy;
   assign pay_end_o      = pay_end_q;
   assign hdr_o          = hdr_q;
   assign egr_state_o    = egr_q;

   always_comb begin
      ing_d = ing_q;
      case (ing_q)
         ING_IDLE:    if (tx_xfer && !tx_beat_i.sof_n) ing_d = ING_HEAD;
         ING_HEAD:    if (hdr_last) ing_d = frame_eof ? ING_WAIT : ING_PAYLOAD;
         ING_PAYLOAD: if (frame_eof) ing_d = ING_WAIT;
         ING_WAIT:    if (trl_done_i) ing_d = ING_IDLE;
         default:     ing_d = ING_IDLE;
      endcase
   end

   always_comb begin
      egr_d = egr_q;
      case (egr_q)
         EGR_IDLE: begin
            if (hdr_last && is_copy) begin
               egr_d = EGR_PAYLOAD;
            end else if (frame_eof && !is_copy) begin
               // other opcodes get the trailer alone
               egr_d = EGR_TRAILER;
            end
         end
         EGR_PAYLOAD: if (pay_done_i) egr_d = EGR_TRAILER;
         EGR_TRAILER: if (trl_done_i) egr_d = EGR_DONE;
         default:     egr_d = EGR_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ing_q      <= ING_IDLE;
         egr_q      <= EGR_IDLE;
         hdr_cnt_q  <= '0;
         eop_take_q <= 1'b0;
         pay_end_q  <= 1'b0;
      end else begin
         ing_q <= ing_d;
         egr_q <= egr_d;
         if ((ing_q == ING_IDLE) && tx_xfer && !tx_beat_i.sof_n) begin
            hdr_cnt_q <= HDR_CNT_W'(1);
         end else if ((ing_q == ING_HEAD) && tx_xfer) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
         end
         // high in the cycle cu_pack pushes the EOP entry
         eop_take_q <= (pay_take_o && !tx_beat_i.eop_n) ||
                       (hdr_last && is_copy && frame_eof);
         if (trl_done_i) begin
            pay_end_q <= 1'b0;
         end else if (eop_take_q) begin
            pay_end_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if ((ing_q == ING_HEAD) && tx_xfer) begin
         if (hdr_cnt_q == HDR_CNT_W'(HDR_OP_IDX)) begin
            hdr_q.op <= op_e'(tx_beat_i.data[DATA_W-1 -: OP_W]);
         end
         if (hdr_cnt_q == HDR_CNT_W'(HDR_LEN_IDX)) begin
            hdr_q.len <= tx_beat_i.data;
         end
         if (hdr_cnt_q == HDR_CNT_W'(HDR_TASK_IDX)) begin
            hdr_q.task_idx <= tx_beat_i.data[TASK_W-1:0];
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/cu_egress.sv
`timescale 1ns/1ps
`default_nettype none

module cu_egress (
   input  logic               clk,
   input  logic               rst_n,
   input  cu_pkg::egr_state_e egr_state_i,
   input  cu_pkg::hdr_t       hdr_i,
   input  logic               pay_end_i,
   input  cu_pkg::entry_t     entry_i,
   input  logic               empty_i,
   output logic               pop_o,
   output logic               pay_done_o,
   output logic               trl_done_o,
   output cu_pkg::ll_beat_t   rx_beat_o,
   output logic               rx_src_rdy_n_o,
   input  logic               rx_dst_rdy_n_i
);
   import cu_pkg::*;

   ll_beat_t             beat_q;
   ll_beat_t             pay_beat;
   ll_beat_t             trl_beat;
   logic                 src_rdy_n_q;
   logic                 fin_q;
   logic                 last_q;
   logic                 half_q;
   logic                 pay_fin;
   logic                 pay_last;
   logic                 first;
   logic                 xfer;
   logic                 in_pay;
   logic                 in_trl;
   logic                 pay_load;
   logic                 trl_load;
   logic                 status;
   logic [WCNT_W-1:0]    wcnt_q;
   logic [TRL_CNT_W-1:0] tcnt_q;
   logic [WCNT_W:0]      len_words;

   assign xfer     = !src_rdy_n_q && !rx_dst_rdy_n_i;
   assign in_pay   = egr_state_i == EGR_PAYLOAD;
   assign in_trl   = egr_state_i == EGR_TRAILER;
   // reload only from an empty output register
   assign pay_load = in_pay && src_rdy_n_q && !empty_i;
   assign trl_load = in_trl && src_rdy_n_q;
   assign first    = wcnt_q == '0;

   assign pop_o      = xfer && in_pay && fin_q;
   // a copy frame without payload words ends once ingress has finished
   assign pay_done_o = (xfer && in_pay && last_q) ||
                       (in_pay && pay_end_i && empty_i && src_rdy_n_q && first);
   assign trl_done_o = xfer && in_trl && !beat_q.eof_n;

   // source length in words, rounded up
   assign len_words = {1'b0, hdr_i.len[DATA_W-1:2]} + (WCNT_W + 1)'(|hdr_i.len[1:0]);
   assign status    = (hdr_i.op == OP_COPY) && ({1'b0, wcnt_q} <= len_words);

   assign rx_beat_o      = beat_q;
   assign rx_src_rdy_n_o = src_rdy_n_q;

   always_comb begin
      pay_fin        = half_q || !entry_i.two;
      pay_last       = pay_fin && entry_i.last;
      pay_beat.data  = half_q ? entry_i.lo : entry_i.hi;
      pay_beat.rem   = pay_last ? entry_i.rem : '0;
      pay_beat.sof_n = !first;
      pay_beat.sop_n = !first;
      pay_beat.eop_n = !pay_last;
      pay_beat.eof_n = 1'b1;
   end

   always_comb begin
      trl_beat = LL_IDLE;
      if (tcnt_q == '0) begin
         trl_beat.data  = {hdr_i.op, status, {(DATA_W - OP_W - 1){1'b0}}};
         trl_beat.sof_n = !first;
         trl_beat.sop_n = !first;
      end else if (tcnt_q == TRL_CNT_W'(TRL_WORDS - 1)) begin
         trl_beat.data  = {{(DATA_W - TASK_W){1'b0}}, hdr_i.task_idx};
         trl_beat.eof_n = 1'b0;
      end else begin
         // byte count
         trl_beat.data = {wcnt_q, 2'b00};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         beat_q      <= LL_IDLE;
         src_rdy_n_q <= 1'b1;
         fin_q       <= 1'b0;
         last_q      <= 1'b0;
         half_q      <= 1'b0;
         wcnt_q      <= '0;
         tcnt_q      <= '0;
      end else begin
         if (pay_load) begin
            beat_q      <= pay_beat;
            fin_q       <= pay_fin;
            last_q      <= pay_last;
            src_rdy_n_q <= 1'b0;
         end else if (trl_load) begin
            beat_q      <= trl_beat;
            src_rdy_n_q <= 1'b0;
         end else if (xfer) begin
            src_rdy_n_q <= 1'b1;
         end
         if (xfer && in_pay) begin
            wcnt_q <= wcnt_q + 1'b1;
            half_q <= !fin_q;
         end
         if (trl_done_o) begin
            wcnt_q <= '0;
            tcnt_q <= '0;
         end else if (xfer && in_trl) begin
            tcnt_q <= tcnt_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/cu_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cu_fifo (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           push_i,
   input  cu_pkg::entry_t entry_i,
   input  logic           pop_i,
   output cu_pkg::entry_t entry_o,
   output logic           full_o,
   output logic           empty_o
);
   import cu_pkg::*;

   entry_t                mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr_q;
   logic [FIFO_PTR_W-1:0] rd_ptr_q;
   logic [FIFO_PTR_W:0]   count_q;
   logic                  at_top;
   logic                  do_push;
   logic                  do_pop;

   assign at_top  = count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH);
   assign empty_o = count_q == '0;
   assign do_push = push_i && !at_top;
   assign do_pop  = pop_i && !empty_o;
   // also full while the last free slot is being written
   assign full_o  = at_top ||
                    (push_i && (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH - 1)));
   assign entry_o = mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= entry_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/cu_pack.sv
`timescale 1ns/1ps
`default_nettype none

module cu_pack (
   input  logic             clk,
   input  logic             rst_n,
   input  cu_pkg::ll_beat_t beat_i,
   input  logic             take_i,
   output logic             push_o,
   output cu_pkg::entry_t   entry_o
);
   import cu_pkg::*;

   logic [DATA_W-1:0] word;
   logic [DATA_W-1:0] hold_q;
   logic              have_hi_q;
   logic              push_q;
   logic              is_eop;
   entry_t            entry_q;

   assign is_eop  = !beat_i.eop_n;
   assign push_o  = push_q;
   assign entry_o = entry_q;

   // clear the bytes past the remainder on the last word
   always_comb begin
      word = beat_i.data;
      if (is_eop) begin
         case (beat_i.rem)
            4'b0001: word = {beat_i.data[DATA_W-1:8], 8'h00};
            4'b0011: word = {beat_i.data[DATA_W-1:16], 16'h0000};
            4'b0111: word = {beat_i.data[DATA_W-1:24], 24'h000000};
            default: word = beat_i.data;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         push_q    <= 1'b0;
         have_hi_q <= 1'b0;
      end else begin
         push_q <= take_i && (have_hi_q || is_eop);
         if (take_i) begin
            have_hi_q <= !have_hi_q && !is_eop;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take_i) begin
         if (have_hi_q) begin
            entry_q.hi  <= hold_q;
            entry_q.lo  <= word;
            entry_q.two <= 1'b1;
         end else begin
            // single-word entry unless a second word follows
            hold_q      <= word;
            entry_q.hi  <= word;
            entry_q.lo  <= '0;
            entry_q.two <= 1'b0;
         end
         entry_q.last <= is_eop;
         entry_q.rem  <= is_eop ? beat_i.rem : '0;
      end
   end

endmodule

`default_nettype wire

// File: rtl/cu_pkg.sv
`default_nettype none

package cu_pkg;

   localparam int DATA_W       = 32;
   localparam int REM_W        = 4;
   localparam int OP_W         = 3;
   localparam int HDR_WORDS    = 8;
   localparam int HDR_CNT_W    = $clog2(HDR_WORDS);
   localparam int HDR_OP_IDX   = 4;
   localparam int HDR_LEN_IDX  = 5;
   localparam int HDR_TASK_IDX = 6;
   localparam int TASK_W       = 10;
   localparam int FIFO_DEPTH   = 8;
   localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
   localparam int TRL_WORDS    = 3;
   localparam int TRL_CNT_W    = $clog2(TRL_WORDS);
   // word count narrow enough that times 4 fits in 32 bits
   localparam int WCNT_W       = DATA_W - 2;

   // one-hot in header bits 31:29
   typedef enum logic [OP_W-1:0] {
      OP_COPY   = 3'b001,
      OP_DECOMP = 3'b010,
      OP_COMP   = 3'b100
   } op_e;

   typedef enum logic [1:0] {
      ING_IDLE,
      ING_HEAD,
      ING_PAYLOAD,
      ING_WAIT
   } ing_state_e;

   typedef enum logic [1:0] {
      EGR_IDLE,
      EGR_PAYLOAD,
      EGR_TRAILER,
      EGR_DONE
   } egr_state_e;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [REM_W-1:0]  rem;
      logic              sof_n;
      logic              eof_n;
      logic              sop_n;
      logic              eop_n;
   } ll_beat_t;

   typedef struct packed {
      op_e               op;
      logic [DATA_W-1:0] len;
      logic [TASK_W-1:0] task_idx;
   } hdr_t;

   typedef struct packed {
      logic [DATA_W-1:0] hi;
      logic [DATA_W-1:0] lo;
      logic              two;
      logic              last;
      logic [REM_W-1:0]  rem;
   } entry_t;

   localparam ll_beat_t LL_IDLE = '{
      data:  '0,
      rem:   '0,
      sof_n: 1'b1,
      eof_n: 1'b1,
      sop_n: 1'b1,
      eop_n: 1'b1
   };

endpackage

`default_nettype wire

// File: src.f
rtl/cu_pkg.sv
rtl/cu_ctrl.sv
rtl/cu_pack.sv
rtl/cu_fifo.sv
rtl/cu_egress.sv
rtl/comp_unit.sv
tests/tb_clk.sv
tests/tb_comp_unit.sv

// File: tests/tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk #(
   parameter int PERIOD_NS  = 4,
   parameter int RST_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // release just after an edge, like the other inputs
   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      #1;
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: tests/tb_comp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_comp_unit #(
   parameter int TIMEOUT_CYC = 1000
);
   import cu_pkg::*;

   typedef logic [DATA_W-1:0] word_q_t[$];

   logic     clk;
   logic     rst_n;
   ll_beat_t tx_beat;
   logic     tx_src_rdy_n;
   logic     tx_dst_rdy_n;
   ll_beat_t rx_beat;
   logic     rx_src_rdy_n;
   logic     rx_dst_rdy_n;

   ll_beat_t exp_q[$];
   hdr_t     exp_hdr_q[$];
   word_q_t  pay_q;
   int       err_cnt = 0;
   int       check_cnt = 0;
   int       tests_run = 0;
   int       tests_failed = 0;
   logic     timed_out = 1'b0;
   logic     gaps_on = 1'b0;

   tb_clk #(.PERIOD_NS(4), .RST_CYCLES(5)) u_clk (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   comp_unit uut (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_beat_i      (tx_beat),
      .tx_src_rdy_n_i (tx_src_rdy_n),
      .tx_dst_rdy_n_o (tx_dst_rdy_n),
      .rx_beat_o      (rx_beat),
      .rx_src_rdy_n_o (rx_src_rdy_n),
      .rx_dst_rdy_n_i (rx_dst_rdy_n)
   );

   // zero the bytes past the remainder code
   function automatic logic [DATA_W-1:0] mask_word(input logic [DATA_W-1:0] d,
                                                   input logic [REM_W-1:0] rem);
      logic [DATA_W-1:0] keep;
      case (rem)
         4'b0001: keep = 32'hffff_ff00;
         4'b0011: keep = 32'hffff_0000;
         4'b0111: keep = 32'hff00_0000;
         default: keep = 32'hffff_ffff;
      endcase
      return d & keep;
   endfunction

   // expected egress beats for one frame
   function automatic void build_expected(input hdr_t h, input word_q_t pay,
                                          input logic [REM_W-1:0] last_rem);
      ll_beat_t        b;
      int              n;
      logic [DATA_W:0] len_words;
      logic            status;
      n = (h.op == OP_COPY) ? pay.size() : 0;
      for (int i = 0; i < n; i++) begin
         b = LL_IDLE;
         b.data  = (i == n - 1) ? mask_word(pay[i], last_rem) : pay[i];
         b.rem   = (i == n - 1) ? last_rem : '0;
         b.sof_n = (i != 0);
         b.sop_n = (i != 0);
         b.eop_n = (i != n - 1);
         exp_q.push_back(b);
      end
      len_words = ({1'b0, h.len} + (DATA_W + 1)'(3)) >> 2;
      status    = (h.op == OP_COPY) && ((DATA_W + 1)'(n) <= len_words);
      b = LL_IDLE;
      b.data  = {h.op, status, {(DATA_W - OP_W - 1){1'b0}}};
      b.sof_n = (n != 0);
      b.sop_n = (n != 0);
      exp_q.push_back(b);
      b = LL_IDLE;
      b.data = DATA_W'(n * 4);
      exp_q.push_back(b);
      b = LL_IDLE;
      b.data  = {{(DATA_W - TASK_W){1'b0}}, h.task_idx};
      b.eof_n = 1'b0;
      exp_q.push_back(b);
   endfunction

   task automatic check_beat(input ll_beat_t got, input ll_beat_t want, input string name);
      check_cnt++;
      if (got !== want) begin
         // data, rem, then sof/eof/sop/eop
         $display("CHECK FAILED t=%0t %s got=%h %b %b exp=%h %b %b", $time, name,
                  got.data, got.rem, got[3:0], want.data, want.rem, want[3:0]);
         err_cnt++;
      end
   endtask

   task automatic check_op(input op_e got, input op_e want, input string name);
      check_cnt++;
      if (got !== want) begin
         $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, want);
         err_cnt++;
      end
   endtask

   task automatic check_task(input logic [TASK_W-1:0] got, input logic [TASK_W-1:0] want,
                             input string name);
      check_cnt++;
      if (got !== want) begin
         $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, want);
         err_cnt++;
      end
   endtask

   task automatic check_bit(input logic got, input logic want, input string name);
      check_cnt++;
      if (got !== want) begin
         $display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, want);
         err_cnt++;
      end
   endtask

   task automatic note_timeout(input string what);
      if (!timed_out) begin
         $display("ERROR: timed out at %0t waiting for %s", $time, what);
         err_cnt++;
      end
      timed_out = 1'b1;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
      tx_src_rdy_n = 1'b1;
      tx_beat      = LL_IDLE;
   endtask

   // returns at the negedge before the accepting edge
   task automatic drive_beat(input ll_beat_t b);
      int   waited;
      logic done;
      waited = 0;
      done   = 1'b0;
      @(posedge clk);
      #1;
      tx_beat      = b;
      tx_src_rdy_n = 1'b0;
      while (!done && !timed_out) begin
         @(negedge clk);
         if (!tx_dst_rdy_n) begin
            done = 1'b1;
         end else begin
            waited++;
            if (waited > TIMEOUT_CYC) note_timeout("ingress accept");
         end
      end
   endtask

   task automatic send_frame(input hdr_t h, input int n, input logic [REM_W-1:0] last_rem);
      logic [DATA_W-1:0] w;
      ll_beat_t          b;
      int                gap;
      pay_q.delete();
      for (int j = 0; j < n; j++) pay_q.push_back($urandom);
      build_expected(h, pay_q, last_rem);
      exp_hdr_q.push_back(h);
      for (int i = 0; i < HDR_WORDS + n; i++) begin
         b = LL_IDLE;
         if (i < HDR_WORDS) begin
            w = $urandom;
            if (i == HDR_OP_IDX) w[DATA_W-1 -: OP_W] = h.op;
            if (i == HDR_LEN_IDX) w = h.len;
            if (i == HDR_TASK_IDX) w[TASK_W-1:0] = h.task_idx;
            b.data  = w;
            b.sof_n = (i != 0);
         end else begin
            b.data  = pay_q[i - HDR_WORDS];
            b.sop_n = (i != HDR_WORDS);
            if (i == HDR_WORDS + n - 1) begin
               b.eop_n = 1'b0;
               b.eof_n = 1'b0;
               b.rem   = last_rem;
            end
         end
         if (gaps_on) begin
            gap = int'($urandom % 3);
            repeat (gap) idle_cycle();
         end
         drive_beat(b);
      end
      idle_cycle();
      // ingress holds off until the trailer is out
      @(negedge clk);
      if (!timed_out) check_bit(tx_dst_rdy_n, 1'b1, "tx_dst_rdy_n_o");
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((exp_q.size() != 0) && !timed_out) begin
         @(posedge clk);
         waited++;
         if (waited > TIMEOUT_CYC) note_timeout("the expected egress beats");
      end
      repeat (2) @(posedge clk);
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      if ((err_cnt == errs_before) && !timed_out) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAILED, %0d errors", tests_run, name, err_cnt - errs_before);
      end
   endtask

   initial begin : rx_ready
      forever begin
         @(posedge clk);
         #1;
         rx_dst_rdy_n = gaps_on ? ($urandom % 4 == 0) : 1'b0;
      end
   end

   // compares every egress transfer in order
   initial begin : monitor
      ll_beat_t          got;
      ll_beat_t          want;
      hdr_t              want_hdr;
      logic [DATA_W-1:0] w_prev1;
      logic [DATA_W-1:0] w_prev2;
      w_prev1 = '0;
      w_prev2 = '0;
      forever begin
         @(negedge clk);
         if (rst_n && !rx_src_rdy_n && !rx_dst_rdy_n) begin
            got = rx_beat;
            if (exp_q.size() == 0) begin
               $display("ERROR: unexpected egress beat at %0t, data %h", $time, got.data);
               err_cnt++;
            end else begin
               want = exp_q.pop_front();
               check_beat(got, want, "rx_beat_o");
            end
            if (!got.eof_n && (exp_hdr_q.size() != 0)) begin
               want_hdr = exp_hdr_q.pop_front();
               check_op(op_e'(w_prev2[DATA_W-1 -: OP_W]), want_hdr.op, "trailer opcode");
               check_task(got.data[TASK_W-1:0], want_hdr.task_idx, "trailer task index");
            end
            w_prev2 = w_prev1;
            w_prev1 = got.data;
         end
      end
   end

   initial begin : main
      hdr_t             h;
      int               n;
      int               l;
      int               errs;
      int               waited;
      logic [REM_W-1:0] rem;
      void'($urandom(32'h7fbe));
      tx_beat      = LL_IDLE;
      tx_src_rdy_n = 1'b1;
      rx_dst_rdy_n = 1'b0;
      waited       = 0;
      while (!rst_n && !timed_out) begin
         @(posedge clk);
         waited++;
         if (waited > TIMEOUT_CYC) note_timeout("reset release");
      end

      errs = err_cnt;
      @(negedge clk);
      check_beat(rx_beat, LL_IDLE, "rx_beat_o");
      repeat (20) begin
         @(negedge clk);
         check_bit(rx_src_rdy_n, 1'b1, "rx_src_rdy_n_o");
         check_bit(tx_dst_rdy_n, 1'b0, "tx_dst_rdy_n_o");
      end
      finish_test("idle after reset", errs);

      errs = err_cnt;
      h.op       = OP_COPY;
      h.len      = 32'd24;
      h.task_idx = 10'h2a5;
      send_frame(h, 6, 4'b0000);
      wait_drain();
      finish_test("copy even words", errs);

      // one frame per remainder code with odd counts
      errs = err_cnt;
      for (int k = 0; k < 4; k++) begin
         n          = 2 * k + 1;
         rem        = REM_W'((1 << k) - 1);
         h.op       = OP_COPY;
         h.len      = DATA_W'((n - 1) * 4 + (4 - k));
         h.task_idx = TASK_W'(k + 3);
         send_frame(h, n, rem);
         wait_drain();
      end
      finish_test("copy odd words and remainders", errs);

      errs = err_cnt;
      h.op       = OP_COPY;
      h.len      = 32'd20;
      h.task_idx = 10'h11f;
      send_frame(h, 9, 4'b0011);
      h.len      = 32'd16;
      h.task_idx = 10'h3ff;
      send_frame(h, 5, 4'b0000);
      wait_drain();
      finish_test("payload over source length", errs);

      errs = err_cnt;
      h.op       = OP_COMP;
      h.len      = 32'd16;
      h.task_idx = 10'h0c4;
      send_frame(h, 4, 4'b0000);
      h.op       = OP_DECOMP;
      h.task_idx = 10'h201;
      send_frame(h, 3, 4'b0001);
      wait_drain();
      finish_test("unsupported opcodes", errs);

      // back to back with gaps on both sides
      errs    = err_cnt;
      gaps_on = 1'b1;
      for (int f = 0; f < 6; f++) begin
         n = 1 + int'($urandom % 20);
         l = n * 4 + int'($urandom % 9) - 6;
         if (l < 0) l = 0;
         h.op       = ($urandom % 4 == 0) ? OP_DECOMP : OP_COPY;
         h.len      = DATA_W'(l);
         h.task_idx = TASK_W'($urandom);
         rem        = REM_W'((1 << ($urandom % 4)) - 1);
         send_frame(h, n, rem);
      end
      wait_drain();
      gaps_on = 1'b0;
      finish_test("random ready gaps", errs);

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_cnt, err_cnt);
      if ((err_cnt == 0) && !timed_out) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire
